// File: common/tx_pkg.sv
/*
 * Transmit path shared types
 * Word, byte mask and frame count types plus the buffer entry
 */

package tx_pkg;

    //--------------------------------------------------
    // Payload types
    //--------------------------------------------------
    typedef logic [63:0] qword_t;                   // One bus word
    typedef logic [7:0]  keep_t;                    // Bit i marks byte i valid

    // Frame counter shared by hardware and host
    typedef logic [31:0] frame_cnt_t;

    //--------------------------------------------------
    // Buffer entry
    //--------------------------------------------------
    typedef struct packed {
        qword_t data;                               // Payload
        keep_t  keep;                               // Valid bytes
        logic   last;                               // Closes the frame
    } tx_word_t;                                    // 73 bits

    // Default buffer address width, 32 words
    parameter int BW_DEF = 5;

endpackage

// File: hdl/tx_ibuf.sv
/*
 * Transmit buffer
 * Dual clock RAM, written from the host side and read
 * with one cycle of latency on the MAC side
 */

`timescale 1ns/1ps

module tx_ibuf import tx_pkg::*; #(
    parameter int BW = 5                            // Address width
) (
    input  logic          wr_clk,                   // Host side clock
    input  logic          wr_en,
    input  logic [BW-1:0] wr_addr,
    input  tx_word_t      wr_entry,
    input  logic          rd_clk,                   // MAC side clock
    input  logic [BW-1:0] rd_addr,
    output tx_word_t      rd_entry                  // Valid one rd_clk later
);

    tx_word_t mem [2**BW];                          // Frame storage

    //--------------------------------------------------
    // Write port
    //--------------------------------------------------
    always_ff @(posedge wr_clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_entry;
        end
    end

    //--------------------------------------------------
    // Read port
    //--------------------------------------------------
    always_ff @(posedge rd_clk) begin
        rd_entry <= mem[rd_addr];                   // Registered read
    end

endmodule

// File: hdl/ptr_sync.sv
/*
 * Pointer synchronizer
 * Gray codes a binary pointer in the source domain,
 * then moves it across clock domains through two flops
 */

`timescale 1ns/1ps

module ptr_sync #(
    parameter int W = 6                             // Pointer width
) (
    input  logic         clk_in,                    // Source domain
    input  logic         clk_out,                   // Destination domain
    input  logic         rst_n,
    input  logic [W-1:0] ptr_in,
    output logic [W-1:0] ptr_out
);

    logic [W-1:0] gray_q;                           // Launch register
    logic [W-1:0] meta_q;                           // First capture flop
    logic [W-1:0] sync_q;                           // Second capture flop

    function automatic logic [W-1:0] gray2bin(input logic [W-1:0] g);
        logic [W-1:0] b;
        b[W-1] = g[W-1];
        for (int i = W - 2; i >= 0; i--) begin
            b[i] = b[i+1] ^ g[i];                   // Prefix XOR from the top
        end
        return b;
    endfunction

    //--------------------------------------------------
    // Source side
    //--------------------------------------------------
    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            gray_q <= '0;
        end else begin
            gray_q <= ptr_in ^ (ptr_in >> 1);       // One bit flips per step
        end
    end

    //--------------------------------------------------
    // Destination side
    //--------------------------------------------------
    always_ff @(posedge clk_out) begin
        if (!rst_n) begin
            meta_q <= '0;
            sync_q <= '0;
        end else begin
            meta_q <= gray_q;                       // May go metastable
            sync_q <= meta_q;
        end
    end

    assign ptr_out = gray2bin(sync_q);              // Back to binary

endmodule

// File: hdl/ibuf_writer.sv
/*
 * Host side frame writer
 * Fills the transmit buffer, tracks free space, commits whole
 * frames to the reader and counts them for the interrupt logic
 */

`timescale 1ns/1ps

module ibuf_writer import tx_pkg::*; #(
    parameter int BW = 5                            // Buffer address width
) (
    input  logic          pcie_clk,
    input  logic          rst_n,
    // Host port
    input  logic          host_wr,                  // One word per strobe
    input  tx_word_t      host_word,
    output logic          space_avail,              // At least one free word
    // Buffer write port
    output logic          wr_en,
    output logic [BW-1:0] wr_addr,
    output tx_word_t      wr_entry,
    // Pointer exchange with the reader
    output logic [BW:0]   committed_prod,           // End of last whole frame
    input  logic [BW:0]   committed_cons,           // Already synchronized
    // Frame accounting
    output logic          frame_done,               // One cycle per frame
    output frame_cnt_t    hw_ptr                    // Frames committed so far
);

    logic [BW:0] wr_ptr;                            // Running write pointer
    logic [BW:0] fill;                              // Words held in the buffer
    logic [BW:0] wr_ptr_inc;

    //--------------------------------------------------
    // Occupancy
    //--------------------------------------------------
    assign fill        = wr_ptr - committed_cons;   // Wrap bit keeps this exact
    assign space_avail = ~fill[BW];                 // Top bit set only when full
    assign wr_ptr_inc  = wr_ptr + 1'b1;

    //--------------------------------------------------
    // Buffer write
    //--------------------------------------------------
    assign wr_en    = host_wr & space_avail;        // Writes into a full buffer are dropped
    assign wr_addr  = wr_ptr[BW-1:0];
    assign wr_entry = host_word;

    //--------------------------------------------------
    // Pointers and frame count
    //--------------------------------------------------
    always_ff @(posedge pcie_clk) begin
        if (!rst_n) begin
            wr_ptr         <= '0;
            committed_prod <= '0;
            hw_ptr         <= '0;
            frame_done     <= 1'b0;
        end else begin
            frame_done <= 1'b0;                     // Pulse by default
            if (wr_en) begin
                wr_ptr <= wr_ptr_inc;
                if (host_word.last) begin
                    // Frame complete so the reader may now see it
                    committed_prod <= wr_ptr_inc;   // Includes this word
                    hw_ptr         <= hw_ptr + 1'b1;
                    frame_done     <= 1'b1;
                end
            end
        end
    end

endmodule

// File: hdl/ibuf2mac.sv
/*
 * MAC side frame reader
 * Detects committed frames, starts the MAC with start/ack and
 * streams the rest of the frame without gaps
 */

`timescale 1ns/1ps

module ibuf2mac import tx_pkg::*; #(
    parameter int BW = 5                            // Buffer address width
) (
    input  logic          mac_clk,
    input  logic          rst_n,
    // Buffer read port
    output logic [BW-1:0] rd_addr,
    input  tx_word_t      rd_entry,                 // One cycle after rd_addr
    // Pointer exchange with the writer
    input  logic [BW:0]   committed_prod,           // Already synchronized
    output logic [BW:0]   committed_cons,           // End of last sent frame
    // MAC transmit
    output qword_t        mac_tx_data,
    output keep_t         mac_tx_data_valid,
    output logic          mac_tx_start,
    input  logic          mac_tx_ack
);

    typedef enum logic [1:0] {IDLE, FETCH, START, STREAM} state_t;

    state_t      state;
    logic [BW:0] rd_ptr;                            // Word held by rd_entry
    logic [BW:0] rd_ptr_nxt;
    tx_word_t    out_word;                          // Word on the MAC bus
    logic        load;                              // Move rd_entry to output
    logic        done;                              // Last word leaves this cycle

    //--------------------------------------------------
    // Read address runs one step ahead
    //--------------------------------------------------
    assign load = (state == FETCH) ||
                  (state == START && mac_tx_ack && !out_word.last) ||
                  (state == STREAM && !out_word.last);
    assign done = ((state == START && mac_tx_ack) || state == STREAM) && out_word.last;

    assign rd_ptr_nxt = load ? rd_ptr + 1'b1 : rd_ptr;
    assign rd_addr    = rd_ptr_nxt[BW-1:0];         // Lands in rd_entry with rd_ptr

    //--------------------------------------------------
    // FSM
    //--------------------------------------------------
    always_ff @(posedge mac_clk) begin
        if (!rst_n) begin
            state          <= IDLE;
            rd_ptr         <= '0;
            committed_cons <= '0;
        end else begin
            rd_ptr <= rd_ptr_nxt;
            case (state)
                IDLE: begin
                    if (committed_prod != committed_cons) begin
                        state <= FETCH;             // Whole frame waiting
                    end
                end
                FETCH: state <= START;              // First word now in rd_entry
                START: begin
                    if (mac_tx_ack) begin
                        state <= out_word.last ? IDLE : STREAM;
                    end
                end
                STREAM: begin
                    if (out_word.last) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
            if (done) begin
                committed_cons <= rd_ptr;           // Frees the frame's words
            end
        end
    end

    always_ff @(posedge mac_clk) begin
        if (load) begin
            out_word <= rd_entry;
        end
    end

    //--------------------------------------------------
    // MAC outputs
    //--------------------------------------------------
    assign mac_tx_start      = (state == START);    // Held until ack
    assign mac_tx_data       = out_word.data;
    assign mac_tx_data_valid = (state == START || state == STREAM) ? out_word.keep : '0;

endmodule

// File: hdl/tx_irq_gen.sv
/*
 * Transmit interrupt generator
 * Raises one interrupt per batch of frames the host has not
 * yet acknowledged through its frame count
 */

`timescale 1ns/1ps

module tx_irq_gen import tx_pkg::*; (
    input  logic       pcie_clk,
    input  logic       rst_n,
    input  logic       frame_done,                  // From the writer
    input  frame_cnt_t hw_ptr,                      // Already updated with frame_done
    input  logic       sw_ptr_wr,                   // Host count write strobe
    input  frame_cnt_t sw_ptr,
    output logic       send_irq                     // One cycle pulse
);

    frame_cnt_t sw_ptr_q;                           // Last count from the host
    logic       pending;                            // Irq sent and not yet serviced

    always_ff @(posedge pcie_clk) begin
        if (!rst_n) begin
            sw_ptr_q <= '0;
            pending  <= 1'b0;
            send_irq <= 1'b0;
        end else begin
            send_irq <= 1'b0;
            if (sw_ptr_wr) begin
                sw_ptr_q <= sw_ptr;
                if (hw_ptr != sw_ptr) begin         // Host still behind
                    pending  <= 1'b1;
                    send_irq <= 1'b1;               // Next batch starts now
                end else begin
                    pending  <= 1'b0;               // Host caught up
                end
            end else if (frame_done && !pending && hw_ptr != sw_ptr_q) begin
                pending  <= 1'b1;                   // Start of a new batch
                send_irq <= 1'b1;
            end
        end
    end

endmodule

// File: hdl/tx_top.sv
/*
 * Transmit path top level
 * Host writer, dual clock buffer, pointer crossings, MAC reader
 * and interrupt generator
 */

`timescale 1ns/1ps

module tx_top import tx_pkg::*; #(
    parameter int BW = BW_DEF                       // Buffer address width
) (
    input  logic       pcie_clk,
    input  logic       mac_clk,
    input  logic       rst_n,                       // Sampled in both domains
    // Host
    input  logic       host_wr,
    input  tx_word_t   host_word,
    output logic       space_avail,
    input  logic       sw_ptr_wr,
    input  frame_cnt_t sw_ptr,
    output logic       send_irq,
    output frame_cnt_t hw_ptr,
    // MAC transmit
    output qword_t     mac_tx_data,
    output keep_t      mac_tx_data_valid,
    output logic       mac_tx_start,
    input  logic       mac_tx_ack
);

    //--------------------------------------------------
    // Internal wires
    //--------------------------------------------------
    logic          wr_en;
    logic [BW-1:0] wr_addr;
    tx_word_t      wr_entry;
    logic [BW-1:0] rd_addr;
    tx_word_t      rd_entry;
    logic [BW:0]   committed_prod;                  // pcie_clk domain
    logic [BW:0]   committed_prod_sync;             // mac_clk domain
    logic [BW:0]   committed_cons;                  // mac_clk domain
    logic [BW:0]   committed_cons_sync;             // pcie_clk domain
    logic          frame_done;

    //--------------------------------------------------
    // Host side
    //--------------------------------------------------
    ibuf_writer #(.BW(BW)) writer (
        .pcie_clk       (pcie_clk),
        .rst_n          (rst_n),
        .host_wr        (host_wr),
        .host_word      (host_word),
        .space_avail    (space_avail),
        .wr_en          (wr_en),
        .wr_addr        (wr_addr),
        .wr_entry       (wr_entry),
        .committed_prod (committed_prod),           // To prod_sync
        .committed_cons (committed_cons_sync),      // From cons_sync
        .frame_done     (frame_done),
        .hw_ptr         (hw_ptr)
    );

    tx_irq_gen irq_gen (
        .pcie_clk   (pcie_clk),
        .rst_n      (rst_n),
        .frame_done (frame_done),
        .hw_ptr     (hw_ptr),
        .sw_ptr_wr  (sw_ptr_wr),
        .sw_ptr     (sw_ptr),
        .send_irq   (send_irq)
    );

    //--------------------------------------------------
    // Buffer and crossings
    //--------------------------------------------------
    tx_ibuf #(.BW(BW)) ibuf (
        .wr_clk   (pcie_clk),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_entry (wr_entry),
        .rd_clk   (mac_clk),
        .rd_addr  (rd_addr),
        .rd_entry (rd_entry)
    );

    ptr_sync #(.W(BW + 1)) prod_sync (
        .clk_in  (pcie_clk),
        .clk_out (mac_clk),
        .rst_n   (rst_n),
        .ptr_in  (committed_prod),
        .ptr_out (committed_prod_sync)
    );

    ptr_sync #(.W(BW + 1)) cons_sync (
        .clk_in  (mac_clk),
        .clk_out (pcie_clk),
        .rst_n   (rst_n),
        .ptr_in  (committed_cons),
        .ptr_out (committed_cons_sync)
    );

    //--------------------------------------------------
    // MAC side
    //--------------------------------------------------
    ibuf2mac #(.BW(BW)) reader (
        .mac_clk           (mac_clk),
        .rst_n             (rst_n),
        .rd_addr           (rd_addr),
        .rd_entry          (rd_entry),
        .committed_prod    (committed_prod_sync),   // From prod_sync
        .committed_cons    (committed_cons),        // To cons_sync
        .mac_tx_data       (mac_tx_data),
        .mac_tx_data_valid (mac_tx_data_valid),
        .mac_tx_start      (mac_tx_start),
        .mac_tx_ack        (mac_tx_ack)
    );

endmodule

// File: sim/tx_asserts.sv
/*
 * Transmit path protocol checks
 * Host space rule, MAC start/ack and gapless stream, irq pulse width
 */

`timescale 1ns/1ps

module tx_asserts import tx_pkg::*; (
    input logic  pcie_clk,
    input logic  mac_clk,
    input logic  rst_n,
    input logic  host_wr,
    input logic  space_avail,
    input logic  send_irq,
    input logic  mac_tx_start,
    input logic  mac_tx_ack,
    input keep_t mac_tx_data_valid
);

    int fails = 0;                                  // Read by the testbench

    //--------------------------------------------------
    // Host side
    //--------------------------------------------------
    host_space: assert property (@(posedge pcie_clk) disable iff (!rst_n)
        host_wr |-> space_avail)
        else begin
            $error("host_wr asserted while space_avail low");
            fails++;
        end

    irq_pulse: assert property (@(posedge pcie_clk) disable iff (!rst_n)
        send_irq |=> !send_irq)
        else begin
            $error("send_irq high on two consecutive cycles");
            fails++;
        end

    //--------------------------------------------------
    // MAC side
    //--------------------------------------------------
    start_held: assert property (@(posedge mac_clk) disable iff (!rst_n)
        (mac_tx_start && !mac_tx_ack) |=> mac_tx_start)
        else begin
            $error("mac_tx_start dropped without mac_tx_ack");
            fails++;
        end

    start_word: assert property (@(posedge mac_clk) disable iff (!rst_n)
        mac_tx_start |-> (mac_tx_data_valid != '0))
        else begin
            $error("mac_tx_start without a word");
            fails++;
        end

    // A streamed word always follows another one, so no hole opens mid frame
    no_gap: assert property (@(posedge mac_clk) disable iff (!rst_n)
        (mac_tx_data_valid != '0 && !mac_tx_start) |-> ($past(mac_tx_data_valid) != '0))
        else begin
            $error("mac_tx_data_valid dropped inside a frame");
            fails++;
        end

endmodule

bind tx_top tx_asserts chk (
    .pcie_clk          (pcie_clk),
    .mac_clk           (mac_clk),
    .rst_n             (rst_n),
    .host_wr           (host_wr),
    .space_avail       (space_avail),
    .send_irq          (send_irq),
    .mac_tx_start      (mac_tx_start),
    .mac_tx_ack        (mac_tx_ack),
    .mac_tx_data_valid (mac_tx_data_valid)
);

// File: sim/tb_tx.sv
/*
 * Transmit path testbench
 * Random frames from the host side, a MAC model with random ack
 * delays, a reference queue of written words and an interrupt model
 */

`timescale 1ns/1ps

module tb_tx
    import tx_pkg::*;
();

    localparam int NFRAMES = 40;                    // Second half runs with slow acks
    localparam int TMO     = 2000;                  // Per wait, in clock cycles
    localparam int RUN_TMO = 40000;

    logic       pcie_clk;
    logic       mac_clk;
    logic       rst_n;
    logic       host_wr;
    tx_word_t   host_word;
    logic       space_avail;
    logic       sw_ptr_wr;
    frame_cnt_t sw_ptr;
    logic       send_irq;
    frame_cnt_t hw_ptr;
    qword_t     mac_tx_data;
    keep_t      mac_tx_data_valid;
    logic       mac_tx_start;
    logic       mac_tx_ack;

    tx_word_t    expq[$];                           // Written, not yet seen at the MAC
    int          lenq[$];                           // Frame lengths in words
    logic [31:0] seed      = 32'd74614;
    int          errors    = 0;
    int          timeouts  = 0;
    int          frames_tx = 0;
    int          frames_rx = 0;
    int          irq_cnt   = 0;
    logic        full_seen = 1'b0;                  // space_avail seen low

    tx_top #(.BW(BW_DEF)) dut0 (
        .pcie_clk          (pcie_clk),
        .mac_clk           (mac_clk),
        .rst_n             (rst_n),
        .host_wr           (host_wr),
        .host_word         (host_word),
        .space_avail       (space_avail),
        .sw_ptr_wr         (sw_ptr_wr),
        .sw_ptr            (sw_ptr),
        .send_irq          (send_irq),
        .hw_ptr            (hw_ptr),
        .mac_tx_data       (mac_tx_data),
        .mac_tx_data_valid (mac_tx_data_valid),
        .mac_tx_start      (mac_tx_start),
        .mac_tx_ack        (mac_tx_ack)
    );

    initial begin
        pcie_clk = 1'b0;
        forever #4 pcie_clk = ~pcie_clk;            // 8 ns
    end

    initial begin
        mac_clk = 1'b0;
        forever #3.2 mac_clk = ~mac_clk;            // 6.4 ns, beats against pcie_clk
    end

    //--------------------------------------------------
    // Helpers
    //--------------------------------------------------
    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic int rand_below(int n);
        return int'((lcg_next() >> 8) % n);         // Low bits of an LCG are weak
    endfunction

    task automatic value_mismatch(string name, logic [63:0] exp_val, logic [63:0] got_val);
        errors++;
        $display("FAILED t=%0t %s expected %h got %h", $time, name, exp_val, got_val);
    endtask

    task automatic protocol_error(string what);
        errors++;
        $display("ERROR t=%0t %s", $time, what);
    endtask

    task automatic wait_expired(string what);
        timeouts++;
        $display("TIMEOUT t=%0t gave up waiting for %s", $time, what);
    endtask

    task automatic check_word(tx_word_t exp_word);
        assert (mac_tx_data == exp_word.data)
            else value_mismatch("mac_tx_data", exp_word.data, mac_tx_data);
        assert (mac_tx_data_valid == exp_word.keep)
            else value_mismatch("mac_tx_data_valid", 64'(exp_word.keep), 64'(mac_tx_data_valid));
    endtask

    //--------------------------------------------------
    // Host side
    //--------------------------------------------------
    initial begin : host_side
        int       len;
        int       t;
        tx_word_t w;
        host_wr   <= 1'b0;
        host_word <= '0;
        sw_ptr_wr <= 1'b0;
        sw_ptr    <= '0;
        repeat (6) @(posedge pcie_clk);             // Past reset
        for (int f = 0; f < NFRAMES; f++) begin
            len = 1 + rand_below(12);
            for (int i = 0; i < len; i++) begin
                w.data = {lcg_next(), lcg_next()};
                w.last = (i == len - 1);
                w.keep = w.last ? 8'hff >> rand_below(8) : 8'hff;  // Partial tail only
                t = 0;
                @(negedge pcie_clk);
                while (!space_avail && t < TMO) begin
                    @(negedge pcie_clk);
                    t++;
                end
                if (!space_avail) wait_expired("space_avail");
                @(posedge pcie_clk);
                host_wr   <= 1'b1;
                host_word <= w;
                @(posedge pcie_clk);                // Word taken on this edge
                host_wr   <= 1'b0;
                expq.push_back(w);
            end
            lenq.push_back(len);
            frames_tx++;
            @(negedge pcie_clk);                    // One cycle after the last word
            assert (hw_ptr == frame_cnt_t'(frames_tx))
                else value_mismatch("hw_ptr", 64'(frames_tx), 64'(hw_ptr));
            if (f % 4 == 3) begin                   // Host services its interrupt
                @(posedge pcie_clk);
                sw_ptr_wr <= 1'b1;
                sw_ptr    <= frame_cnt_t'(frames_tx - ((f % 8 == 3) ? 1 : 0));  // Lags or equals
                @(posedge pcie_clk);
                sw_ptr_wr <= 1'b0;
            end
        end
    end

    //--------------------------------------------------
    // MAC model
    //--------------------------------------------------
    initial begin : mac_side
        tx_word_t exp_word;
        int       len;
        int       delay;
        int       cyc;
        int       t;
        mac_tx_ack <= 1'b0;
        repeat (8) @(posedge mac_clk);
        for (int f = 0; f < NFRAMES; f++) begin
            t = 0;
            @(negedge mac_clk);
            while (!mac_tx_start && t < TMO) begin
                @(negedge mac_clk);
                t++;
            end
            if (!mac_tx_start) begin
                wait_expired("mac_tx_start");
                break;
            end
            if (expq.size() == 0 || lenq.size() == 0) begin
                protocol_error("MAC started a frame that was never written");
                break;
            end
            exp_word = expq.pop_front();
            len      = lenq.pop_front();
            delay    = (f < NFRAMES / 2) ? rand_below(8) : 40 + rand_below(40);  // Slow half
            repeat (delay) begin
                assert (mac_tx_start) else protocol_error("mac_tx_start fell before mac_tx_ack");
                check_word(exp_word);               // First word holds
                @(negedge mac_clk);
            end
            @(posedge mac_clk);
            mac_tx_ack <= 1'b1;
            @(negedge mac_clk);
            check_word(exp_word);                   // Ack cycle
            @(posedge mac_clk);
            mac_tx_ack <= 1'b0;
            cyc = 0;
            @(negedge mac_clk);
            while (mac_tx_data_valid != '0 && cyc < 16) begin
                cyc++;
                if (expq.size() > 0) begin
                    exp_word = expq.pop_front();
                    check_word(exp_word);           // No gaps allowed
                end else begin
                    protocol_error("MAC received a word that was never written");
                end
                @(negedge mac_clk);
            end
            assert (cyc == len - 1)
                else value_mismatch("cycles from ack to last word", 64'(len - 1), 64'(cyc));
            frames_rx++;
        end
    end

    //--------------------------------------------------
    // Interrupt reference
    //--------------------------------------------------
    logic       p_rst     = 1'b0;                   // Samples of the previous cycle
    logic       p_fd      = 1'b0;
    logic       last_wr_q = 1'b0;
    logic       p_sw_wr   = 1'b0;
    frame_cnt_t p_sw      = '0;
    frame_cnt_t p_hw      = '0;
    frame_cnt_t sw_q      = '0;                     // Host count as last written
    logic       pend      = 1'b0;
    logic       exp_irq   = 1'b0;

    always @(negedge pcie_clk) begin
        if (!p_rst) begin
            pend    = 1'b0;
            sw_q    = '0;
            exp_irq = 1'b0;
        end else if (p_sw_wr) begin
            sw_q    = p_sw;
            exp_irq = (p_hw != p_sw);               // Still behind raises again
            pend    = exp_irq;
        end else begin
            exp_irq = p_fd && !pend && (p_hw != sw_q);
            pend    = pend || exp_irq;
        end
        assert (send_irq == exp_irq)
            else value_mismatch("send_irq", 64'(exp_irq), 64'(send_irq));
        if (send_irq) irq_cnt++;
        if (rst_n && !space_avail) full_seen = 1'b1;
        p_rst     = rst_n;
        p_fd      = last_wr_q;                      // frame_done trails the write by one
        last_wr_q = host_wr && host_word.last && space_avail;
        p_sw_wr   = sw_ptr_wr;
        p_sw      = sw_ptr;
        p_hw      = hw_ptr;
    end

    //--------------------------------------------------
    // Reset and end of run
    //--------------------------------------------------
    initial begin : run_control
        int t;
        rst_n <= 1'b0;
        repeat (4) @(posedge pcie_clk);
        rst_n <= 1'b1;
        t = 0;
        while (frames_rx < NFRAMES && timeouts == 0 && t < RUN_TMO) begin
            @(posedge pcie_clk);
            t++;
        end
        if (t >= RUN_TMO) wait_expired("all frames at the MAC");
        assert (expq.size() == 0) else protocol_error("words left over after the last frame");
        assert (full_seen) else protocol_error("buffer never filled, space_avail stayed high");
        assert (irq_cnt >= 3) else protocol_error("fewer interrupts than the frame pattern needs");
        $display("Errors %0d, timeouts %0d, assertion failures %0d",
                 errors, timeouts, dut0.chk.fails);
        if (errors == 0 && timeouts == 0 && dut0.chk.fails == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: verilog.f
common/tx_pkg.sv
hdl/tx_ibuf.sv
hdl/ptr_sync.sv
hdl/ibuf_writer.sv
hdl/ibuf2mac.sv
hdl/tx_irq_gen.sv
hdl/tx_top.sv
sim/tx_asserts.sv
sim/tb_tx.sv

// File: Makefile
# Verilator build and run for the transmit path testbench

compile:
	verilator --binary --assert -Wno-fatal --top-module tb_tx -f verilog.f -o sim_tx

run: compile
	@out="$$(./obj_dir/sim_tx +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '>>> PASS'

clean:
	rm -rf obj_dir

.PHONY: compile run clean
